//--- Makefile
# Verilator build and run of the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
logic/dcache_pkg.sv
logic/dcache_front.sv
logic/line_store.sv
logic/burst_ctrl.sv
logic/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

//--- logic/burst_ctrl.sv
/*
 * Bus side FSM of the data cache
 * Write-back, refill and flush bursts over AXI-style channels
 */
`timescale 1ns/1ps

module burst_ctrl #(
    parameter int line_words = 128
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         miss_req,
    input  logic                                         flush_req,
    input  dcache_pkg::addr_t                            address,
    input  logic                                         line_dirty,
    input  logic [dcache_pkg::tag_bits(line_words)-1:0]  line_tag,
    input  dcache_pkg::word_t                            wb_word,
    input  logic                                         awready,
    input  logic                                         wready,
    input  logic                                         bvalid,
    input  logic                                         arready,
    input  logic                                         rvalid,
    input  dcache_pkg::word_t                            rdata,
    input  logic                                         rlast,
    output logic                                         ctrl_busy,
    output logic [dcache_pkg::idx_bits(line_words)-1:0]  fill_ptr,
    output logic                                         fill_we,
    output dcache_pkg::word_t                            fill_wdata,
    output logic [dcache_pkg::tag_bits(line_words)-1:0]  fill_tag,
    output logic                                         fill_done,
    output logic                                         invalidate,
    output logic                                         awvalid,
    output dcache_pkg::addr_t                            awaddr,
    output logic [7:0]                                   awlen,
    output logic                                         wvalid,
    output dcache_pkg::word_t                            wdata,
    output logic                                         wlast,
    output logic                                         bready,
    output logic                                         arvalid,
    output dcache_pkg::addr_t                            araddr,
    output logic [7:0]                                   arlen,
    output logic                                         rready
);

    localparam int tag_lo = dcache_pkg::tag_lsb(line_words);
    localparam int idx_w  = dcache_pkg::idx_bits(line_words);
    localparam logic [idx_w-1:0] last_idx = idx_w'(line_words - 1);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    // Write-back was ordered by a flush and ends in IDLE
    logic flushing;
    logic w_beat;
    logic r_beat;

    // ------------------------------------------------------------------
    // Channel outputs decoded from state
    // ------------------------------------------------------------------
    assign ctrl_busy = (state_q != dcache_pkg::IDLE);
    assign awvalid   = (state_q == dcache_pkg::WB_ADDR);
    assign wvalid    = (state_q == dcache_pkg::WB_DATA);
    assign bready    = (state_q == dcache_pkg::WB_RESP);
    assign arvalid   = (state_q == dcache_pkg::FILL_ADDR);
    assign rready    = (state_q == dcache_pkg::FILL_DATA);

    // Whole line bursts from the line base
    assign fill_tag = address[dcache_pkg::addr_w-1:tag_lo];
    assign awaddr   = {line_tag, {tag_lo{1'b0}}};
    assign araddr   = {fill_tag, {tag_lo{1'b0}}};
    assign awlen    = 8'(line_words - 1);
    assign arlen    = 8'(line_words - 1);

    assign w_beat = wvalid && wready;
    assign r_beat = rvalid && rready;

    assign wdata = wb_word;
    assign wlast = wvalid && (fill_ptr == last_idx);

    assign fill_we    = r_beat;
    assign fill_wdata = rdata;
    assign fill_done  = r_beat && rlast;
    // Pulse on entry to the refill
    assign invalidate = (state_d == dcache_pkg::FILL_ADDR) &&
                        (state_q != dcache_pkg::FILL_ADDR);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (flush_req) state_d = dcache_pkg::WB_ADDR;
                else if (miss_req) begin
                    // Dirty line goes back to memory first
                    state_d = line_dirty ? dcache_pkg::WB_ADDR : dcache_pkg::FILL_ADDR;
                end
            end
            dcache_pkg::WB_ADDR: if (awready) state_d = dcache_pkg::WB_DATA;
            dcache_pkg::WB_DATA: if (w_beat && wlast) state_d = dcache_pkg::WB_RESP;
            dcache_pkg::WB_RESP: begin
                if (bvalid) state_d = flushing ? dcache_pkg::IDLE : dcache_pkg::FILL_ADDR;
            end
            dcache_pkg::FILL_ADDR: if (arready) state_d = dcache_pkg::FILL_DATA;
            dcache_pkg::FILL_DATA: if (fill_done) state_d = dcache_pkg::IDLE;
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= dcache_pkg::IDLE;
            fill_ptr <= '0;
            flushing <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_pkg::IDLE) flushing <= flush_req;
            // One step per accepted beat and back to zero after the last
            if ((w_beat && wlast) || fill_done) fill_ptr <= '0;
            else if (w_beat || r_beat) fill_ptr <= fill_ptr + 1'b1;
        end
    end

    // Write address and its payload stay put until accepted
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)));

    // Memory burst length matches the line so the pointer stays in range
    a_ptr_range: assert property (@(posedge clk) disable iff (!rst_n)
        r_beat |-> (rlast == (fill_ptr == last_idx)));

endmodule

//--- logic/dcache_front.sv
/*
 * CPU side of the data cache
 * Hit check, stall level, byte write request and miss/flush pulses
 */
`timescale 1ns/1ps

module dcache_front #(
    parameter int line_words = 128
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  dcache_pkg::addr_t                            address,
    input  dcache_pkg::word_t                            write_data,
    input  logic                                         read_enable,
    input  logic                                         write_enable,
    input  logic [dcache_pkg::be_w-1:0]                  byte_enable,
    input  logic                                         flush_order,
    input  logic [dcache_pkg::tag_bits(line_words)-1:0]  line_tag,
    input  logic                                         line_valid,
    input  dcache_pkg::word_t                            cpu_rdata,
    input  logic                                         ctrl_busy,
    output dcache_pkg::word_t                            read_data,
    output logic                                         stall,
    output logic                                         miss_req,
    output logic                                         flush_req,
    output logic                                         cpu_we,
    output logic [dcache_pkg::idx_bits(line_words)-1:0]  cpu_index,
    output dcache_pkg::word_t                            cpu_wdata,
    output logic [dcache_pkg::be_w-1:0]                  cpu_be
);

    localparam int tag_lo = dcache_pkg::tag_lsb(line_words);

    logic [dcache_pkg::addr_w-1:tag_lo] req_tag;
    logic hit;
    logic wr_act;
    logic access;
    logic miss;
    logic can_issue;
    // Request sent but controller not yet seen busy
    logic req_pending;

    // Address split
    assign req_tag   = address[dcache_pkg::addr_w-1:tag_lo];
    assign cpu_index = address[tag_lo-1:2];

    assign hit = line_valid && (req_tag == line_tag);

    // Empty byte mask means no write at all
    assign wr_act = write_enable && (|byte_enable);
    assign access = read_enable || wr_act;
    assign miss   = access && !hit;

    // ------------------------------------------------------------------
    // Stall and request pulses
    // ------------------------------------------------------------------
    assign can_issue = !ctrl_busy && !req_pending;
    // Flush wins over a miss in the same cycle
    assign flush_req = flush_order && can_issue;
    assign miss_req  = miss && !flush_order && can_issue;

    assign stall = miss || ctrl_busy || req_pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_pending <= 1'b0;
        end else if (miss_req || flush_req) begin
            req_pending <= 1'b1;
        end else if (ctrl_busy) begin
            req_pending <= 1'b0;
        end
    end

    // Hit writes only while the line is not being moved
    assign cpu_we    = wr_act && hit && can_issue;
    assign cpu_wdata = write_data;
    assign cpu_be    = byte_enable;

    // Async read of the addressed word
    assign read_data = cpu_rdata;

    // CPU never reads and writes at once
    a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_enable && write_enable));

    // Controller picks up every request at the next edge
    a_req_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (miss_req || flush_req) |=> ctrl_busy);

endmodule

//--- logic/dcache_pkg.sv
/*
 * Shared widths, word and address types, burst controller states
 * and helpers that derive line geometry from the words per line
 */
package dcache_pkg;

    // Bus and CPU widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int be_w   = data_w / 8;

    typedef logic [data_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // Burst controller states
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } ctrl_state_t;

    // ------------------------------------------------------------------
    // Line geometry
    // | TAG | WORD OFFSET | BYTE (2 bits) |
    // ------------------------------------------------------------------
    function automatic int idx_bits(int words);
        return $clog2(words);
    endfunction

    // Lowest address bit that belongs to the tag
    function automatic int tag_lsb(int words);
        return idx_bits(words) + 2;
    endfunction

    function automatic int tag_bits(int words);
        return addr_w - tag_lsb(words);
    endfunction

endpackage

//--- logic/dcache_top.sv
/*
 * Direct mapped one-line write-back data cache
 * CPU front, line store and burst controller
 */
`timescale 1ns/1ps

module dcache_top #(
    parameter int line_words = 128
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // CPU side
    input  dcache_pkg::addr_t             address,
    input  dcache_pkg::word_t             write_data,
    input  logic                          read_enable,
    input  logic                          write_enable,
    input  logic [dcache_pkg::be_w-1:0]   byte_enable,
    input  logic                          flush_order,
    output dcache_pkg::word_t             read_data,
    output logic                          stall,
    // Memory bus
    output logic                          awvalid,
    input  logic                          awready,
    output dcache_pkg::addr_t             awaddr,
    output logic [7:0]                    awlen,
    output logic                          wvalid,
    input  logic                          wready,
    output dcache_pkg::word_t             wdata,
    output logic                          wlast,
    input  logic                          bvalid,
    output logic                          bready,
    output logic                          arvalid,
    input  logic                          arready,
    output dcache_pkg::addr_t             araddr,
    output logic [7:0]                    arlen,
    input  logic                          rvalid,
    output logic                          rready,
    input  dcache_pkg::word_t             rdata,
    input  logic                          rlast
);

    localparam int idx_w = dcache_pkg::idx_bits(line_words);
    localparam int tag_w = dcache_pkg::tag_bits(line_words);

    // Front and controller handshake
    logic miss_req;
    logic flush_req;
    logic ctrl_busy;

    // Line store ports
    logic                        cpu_we;
    logic [idx_w-1:0]            cpu_index;
    dcache_pkg::word_t           cpu_wdata;
    logic [dcache_pkg::be_w-1:0] cpu_be;
    dcache_pkg::word_t           cpu_rdata;
    dcache_pkg::word_t           wb_word;
    logic [tag_w-1:0]            line_tag;
    logic                        line_valid;
    logic                        line_dirty;
    logic [idx_w-1:0]            fill_ptr;
    logic                        fill_we;
    dcache_pkg::word_t           fill_wdata;
    logic [tag_w-1:0]            fill_tag;
    logic                        fill_done;
    logic                        invalidate;

    dcache_front #(.line_words(line_words)) i_front (
        .clk, .rst_n, .address, .write_data, .read_enable, .write_enable,
        .byte_enable, .flush_order, .line_tag, .line_valid, .cpu_rdata,
        .ctrl_busy, .read_data, .stall, .miss_req, .flush_req, .cpu_we,
        .cpu_index, .cpu_wdata, .cpu_be
    );

    line_store #(.line_words(line_words)) i_store (
        .clk, .rst_n, .cpu_we, .cpu_index, .cpu_wdata, .cpu_be, .fill_ptr,
        .fill_we, .fill_wdata, .fill_tag, .fill_done, .invalidate,
        .cpu_rdata, .wb_word, .line_tag, .line_valid, .line_dirty
    );

    burst_ctrl #(.line_words(line_words)) i_ctrl (
        .clk, .rst_n, .miss_req, .flush_req, .address, .line_dirty, .line_tag,
        .wb_word, .awready, .wready, .bvalid, .arready, .rvalid, .rdata,
        .rlast, .ctrl_busy, .fill_ptr, .fill_we, .fill_wdata, .fill_tag,
        .fill_done, .invalidate, .awvalid, .awaddr, .awlen, .wvalid, .wdata,
        .wlast, .bready, .arvalid, .araddr, .arlen, .rready
    );

endmodule

//--- logic/line_store.sv
/*
 * Single cache line storage
 * Data words, tag, valid and dirty flags with CPU and refill write ports
 */
`timescale 1ns/1ps

module line_store #(
    parameter int line_words = 128
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         cpu_we,
    input  logic [dcache_pkg::idx_bits(line_words)-1:0]  cpu_index,
    input  dcache_pkg::word_t                            cpu_wdata,
    input  logic [dcache_pkg::be_w-1:0]                  cpu_be,
    input  logic [dcache_pkg::idx_bits(line_words)-1:0]  fill_ptr,
    input  logic                                         fill_we,
    input  dcache_pkg::word_t                            fill_wdata,
    input  logic [dcache_pkg::tag_bits(line_words)-1:0]  fill_tag,
    input  logic                                         fill_done,
    input  logic                                         invalidate,
    output dcache_pkg::word_t                            cpu_rdata,
    output dcache_pkg::word_t                            wb_word,
    output logic [dcache_pkg::tag_bits(line_words)-1:0]  line_tag,
    output logic                                         line_valid,
    output logic                                         line_dirty
);

    dcache_pkg::word_t line_mem [line_words];
    dcache_pkg::word_t merged;

    // Combinational reads for CPU and write-back
    assign cpu_rdata = line_mem[cpu_index];
    assign wb_word   = line_mem[fill_ptr];

    // Replace only the enabled bytes
    always_comb begin
        merged = cpu_rdata;
        for (int b = 0; b < dcache_pkg::be_w; b++) begin
            if (cpu_be[b]) merged[8*b +: 8] = cpu_wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_we) line_mem[cpu_index] <= merged;
        if (fill_we) line_mem[fill_ptr] <= fill_wdata;
    end

    // ------------------------------------------------------------------
    // Line flags and tag
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_tag   <= '0;
            line_valid <= 1'b0;
            line_dirty <= 1'b0;
        end else begin
            // Line contents unusable once a refill starts
            if (invalidate) line_valid <= 1'b0;
            else if (fill_done) line_valid <= 1'b1;
            if (fill_done) begin
                line_tag   <= fill_tag;
                line_dirty <= 1'b0;
            end else if (cpu_we) begin
                line_dirty <= 1'b1;
            end
        end
    end

    // CPU writes and bus refills are exclusive in time
    a_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_we && fill_we));

endmodule

//--- verification/mem_model.sv
/*
 * AXI-style burst memory responder for the cache testbench
 * Random ready and valid gaps, word peek port and read burst counters
 */
`timescale 1ns/1ps

module mem_model #(
    parameter int depth = 4096
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stress,
    input  logic        awvalid,
    input  logic        wvalid,
    input  logic        wlast,
    input  logic        bready,
    input  logic        arvalid,
    input  logic        rready,
    input  logic [7:0]  arlen,
    input  logic [31:0] awaddr,
    input  logic [31:0] wdata,
    input  logic [31:0] araddr,
    input  logic [31:0] peek_addr,
    output logic        awready,
    output logic        wready,
    output logic        bvalid,
    output logic        arready,
    output logic        rvalid,
    output logic        rlast,
    output logic        busy,
    output logic [31:0] rdata,
    output logic [31:0] peek_data,
    output int          rd_bursts,
    output int          rd_beats
);

    localparam int aw = $clog2(depth);

    // Word storage, open to the testbench through the peek port
    logic [31:0] mem [depth];
    logic [aw-1:0] rd_idx;
    logic [aw-1:0] wr_idx;
    logic [7:0] rd_cnt;
    logic [7:0] rd_len;
    logic rd_active;
    logic wr_active;
    logic b_pend;
    // Per-cycle gap draws, one per channel
    logic ar_ok;
    logic aw_ok;
    logic w_ok;
    logic r_ok;
    logic b_ok;

    // Low one cycle in four while stressed
    function automatic logic gap_free(logic en);
        return !en || (($urandom % 4) != 0);
    endfunction

    initial begin
        // One seed for the whole run
        void'($urandom(32'ha751));
        // Each word holds its own inverted word address
        for (int i = 0; i < depth; i++) begin
            mem[i] = ~32'(i);
        end
    end

    assign arready   = !rd_active && ar_ok;
    assign rvalid    = rd_active && r_ok;
    assign rdata     = mem[rd_idx + aw'(rd_cnt)];
    assign rlast     = rd_active && (rd_cnt == rd_len);
    assign awready   = !wr_active && !b_pend && aw_ok;
    assign wready    = wr_active && w_ok;
    assign bvalid    = b_pend && b_ok;
    assign peek_data = mem[peek_addr[aw+1:2]];
    assign busy      = rd_active || wr_active || b_pend;

    // ------------------------------------------------------------------
    // Read and write burst engines
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            {ar_ok, aw_ok, w_ok, r_ok, b_ok} <= '0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pend    <= 1'b0;
            rd_cnt    <= '0;
            rd_len    <= '0;
            rd_idx    <= '0;
            wr_idx    <= '0;
            rd_bursts <= 0;
            rd_beats  <= 0;
        end else begin
            ar_ok <= gap_free(stress);
            aw_ok <= gap_free(stress);
            w_ok  <= gap_free(stress);
            r_ok  <= gap_free(stress);
            b_ok  <= gap_free(stress);
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_idx    <= araddr[aw+1:2];
                rd_len    <= arlen;
                rd_cnt    <= '0;
                rd_bursts <= rd_bursts + 1;
            end
            if (rvalid && rready) begin
                rd_beats <= rd_beats + 1;
                rd_cnt   <= rd_cnt + 8'd1;
                if (rlast) rd_active <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_idx    <= awaddr[aw+1:2];
            end
            if (wvalid && wready) begin
                mem[wr_idx] <= wdata;
                wr_idx      <= wr_idx + 1'b1;
                // Response follows the last beat
                if (wlast) begin
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                end
            end
            if (bvalid && bready) b_pend <= 1'b0;
        end
    end

endmodule

//--- verification/tb_dcache.sv
/*
 * Testbench for the one-line data cache
 * Clock, reset, CPU stimulus, checking assertions, reporting and watchdog
 */
`timescale 1ns/1ps

module tb_dcache;

    localparam int line_words = 16;
    localparam int n_tests    = 10;
    // Random gaps stretch each beat by a few cycles at worst
    localparam int bp_factor  = 8;
    localparam int timeout_cycles = n_tests * 4 * (line_words + 2) * bp_factor;

    logic clk = 1'b0;
    logic rst_n;
    logic read_enable;
    logic write_enable;
    logic flush_order;
    logic stall;
    logic stress;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [31:0] read_data;
    logic [3:0] byte_enable;
    // Bus between cache and memory
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic arvalid, arready, rvalid, rready, rlast, mem_busy;
    logic [31:0] awaddr, araddr, wdata, rdata, peek_addr, peek_data;
    logic [7:0] awlen, arlen;
    int rd_bursts;
    int rd_beats;

    // Expected values and check enables
    logic [31:0] shadow [int unsigned];
    logic [31:0] exp_data, mem_exp, exp_wb_base, exp_fill_base;
    logic rd_check, hit_check, miss_check, mem_check, burst_check;
    logic stall_q;
    int exp_bursts;
    int exp_beats;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #10 clk = ~clk;

    // Stall as seen at the last rising edge
    always @(posedge clk) stall_q <= stall;

    dcache_top #(.line_words(line_words)) i_dcache_top (.*);

    mem_model i_mem (.*, .busy(mem_busy));

    function automatic logic [31:0] expected_word(logic [31:0] addr);
        int unsigned w;
        w = addr >> 2;
        return shadow.exists(w) ? shadow[w] : ~w;
    endfunction

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic protocol_error(string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_read: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_check && !stall) |-> (read_data == exp_data))
        else mismatch("read_data", $sampled(read_data), $sampled(exp_data));
    a_hit: assert property (@(posedge clk) disable iff (!rst_n) hit_check |-> !stall)
        else protocol_error("stall rose on an access to the resident line");
    a_miss: assert property (@(posedge clk) disable iff (!rst_n) miss_check |-> stall)
        else protocol_error("no stall in the cycle of a miss");
    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_order && !stall) |=> stall)
        else protocol_error("stall did not follow a flush order");
    a_mem: assert property (@(posedge clk) disable iff (!rst_n)
        mem_check |-> (peek_data == mem_exp))
        else mismatch("memory word", $sampled(peek_data), $sampled(mem_exp));
    a_bursts: assert property (@(posedge clk) disable iff (!rst_n)
        burst_check |-> (rd_bursts == exp_bursts))
        else mismatch("rd_bursts", 32'($sampled(rd_bursts)), 32'($sampled(exp_bursts)));
    a_beats: assert property (@(posedge clk) disable iff (!rst_n)
        burst_check |-> (rd_beats == exp_beats))
        else mismatch("rd_beats", 32'($sampled(rd_beats)), 32'($sampled(exp_beats)));
    a_ar_base: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && arready) |-> (araddr == exp_fill_base))
        else mismatch("araddr", $sampled(araddr), $sampled(exp_fill_base));
    a_aw_base: assert property (@(posedge clk) disable iff (!rst_n)
        (awvalid && awready) |-> (awaddr == exp_wb_base))
        else mismatch("awaddr", $sampled(awaddr), $sampled(exp_wb_base));
    a_len: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid || awvalid) |-> (arlen == 8'(line_words - 1) && awlen == arlen))
        else protocol_error("burst length differs from the line length");
    // Stall only drops once the bus is quiet again
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !stall |-> !(arvalid || awvalid || wvalid || bready || rready || mem_busy))
        else protocol_error("stall low while a burst is still running");

    // ------------------------------------------------------------------
    // CPU side stimulus, driven on falling edges
    // ------------------------------------------------------------------
    task automatic wait_done();
        @(negedge clk);
        miss_check = 1'b0;
        while (stall_q) @(negedge clk);
    endtask

    task automatic read_word(logic [31:0] addr, logic expect_hit);
        address     = addr;
        read_enable = 1'b1;
        exp_data    = expected_word(addr);
        rd_check    = 1'b1;
        hit_check   = expect_hit;
        miss_check  = !expect_hit;
        wait_done();
        read_enable = 1'b0;
        rd_check    = 1'b0;
        hit_check   = 1'b0;
    endtask

    task automatic write_bytes(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
        logic [31:0] merged;
        merged = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[8*b +: 8] = data[8*b +: 8];
        end
        shadow[addr >> 2] = merged;
        address      = addr;
        write_data   = data;
        byte_enable  = be;
        write_enable = 1'b1;
        hit_check    = 1'b1;
        wait_done();
        write_enable = 1'b0;
        byte_enable  = 4'b0000;
        hit_check    = 1'b0;
    endtask

    task automatic flush_line();
        flush_order = 1'b1;
        @(negedge clk);
        flush_order = 1'b0;
        wait_done();
    endtask

    // Walk the memory copy of one line against the shadow
    task automatic check_line(logic [31:0] base);
        mem_check = 1'b1;
        for (int w = 0; w < line_words; w++) begin
            peek_addr = base + 32'(4 * w);
            mem_exp   = expected_word(peek_addr);
            @(negedge clk);
        end
        mem_check = 1'b0;
    endtask

    task automatic burst_tally(int bursts, int beats);
        exp_bursts  = bursts;
        exp_beats   = beats;
        burst_check = 1'b1;
        @(negedge clk);
        burst_check = 1'b0;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("%s: %s", name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    task automatic run_suite(logic [31:0] base_a, logic [31:0] base_b, logic [31:0] prev,
                             string tag);
        int b0;
        int t0;
        exp_wb_base   = prev;
        exp_fill_base = base_a;
        b0 = rd_bursts;
        t0 = rd_beats;
        read_word(base_a + 32'h4, 1'b0);
        burst_tally(b0 + 1, t0 + line_words);
        end_test({tag, " 1 read miss"});
        read_word(base_a + 32'h28, 1'b1);
        end_test({tag, " 2 read hit"});
        write_bytes(base_a + 32'h28, 32'hc0de_5a11 ^ base_a, 4'b0101);
        read_word(base_a + 32'h28, 1'b1);
        end_test({tag, " 3 byte write"});
        // Other tag pushes the dirty line out
        exp_wb_base   = base_a;
        exp_fill_base = base_b;
        read_word(base_b + 32'h10, 1'b0);
        check_line(base_a);
        end_test({tag, " 4 dirty eviction"});
        write_bytes(base_b + 32'h8, 32'h1234_abcd ^ base_b, 4'b1111);
        exp_wb_base = base_b;
        flush_line();
        check_line(base_b);
        read_word(base_b + 32'h8, 1'b1);
        end_test({tag, " 5 flush"});
    endtask

    initial begin
        rst_n        = 1'b0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        flush_order  = 1'b0;
        byte_enable  = 4'b0000;
        address      = '0;
        write_data   = '0;
        stress       = 1'b0;
        peek_addr    = '0;
        {exp_data, mem_exp, exp_wb_base, exp_fill_base} = '0;
        {rd_check, hit_check, miss_check, mem_check, burst_check} = '0;
        exp_bursts   = 0;
        exp_beats    = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        run_suite(32'h1000, 32'h2000, 32'h0, "base");
        // Same flow with random gaps on every channel
        stress = 1'b1;
        run_suite(32'h3000, 32'h0800, 32'h2000, "test 6 gaps");
        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        errors++;
        $display("Timeout after %0d cycles, the cache never finished its accesses",
                 timeout_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
